//--- testbench/sw_tests.txt
# op: idle, query, target or busy-query; le: little_endian level
# word: seq_word in hex; err: expected length_error pulse; result: expected result in hex
idle        0 00000000000000000000 0 0000
query       0 0008000000000000e4e4 0 0000
target      0 0008000000000000e4e4 0 0028
target      0 0008000000000000e7e4 0 001f
target      0 000900000000000390e4 0 001c
target      0 000a00000000000e4ae4 0 0018
query       1 0800e4e4000000000000 0 0000
target      1 0800e4e7000000000000 0 1f00
target      0 0000000000000000e4e4 1 0000
target      0 00210000000000000000 1 0000
query       0 0007000000000000e4e4 1 0000
target      0 0008000000000000e7e4 0 001f
busy-query  0 0008000000000000ffff 0 0000
target      0 0008000000000000e4e4 0 0028
query       0 0008000000000000ffff 0 0000
target      0 000400000000000000ff 0 0014
idle        0 00000000000000000000 0 0000

//--- verilog.f
src/sw_pkg.sv
src/sw_link_if.sv
src/seq_loader.sv
src/sw_pe.sv
src/score_collector.sv
src/sw_top.sv
testbench/sw_assert.sv
testbench/sw_tb.sv

//--- Makefile
SRCS = $(wildcard src/*.sv testbench/*.sv)

.PHONY: run clean

obj_dir/Vsw_tb: verilog.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module sw_tb -f verilog.f -o Vsw_tb

run: obj_dir/Vsw_tb
	./obj_dir/Vsw_tb | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/sw_tb.sv
// Testbench for the scorer; replays the operations of the tests file and checks every response
`timescale 1ns/10ps

module sw_tb;
  import sw_pkg::*;

  localparam int num_pe = 8;   // DUT default

  logic      ha_pclock;
  logic      reset;
  logic      seq_valid;
  logic      seq_target;
  logic      little_endian;
  seq_word_t seq_word;
  logic      busy;
  logic      length_error;
  logic      result_valid;
  result_t   result;
  int        cycle_count = 0;
  int        cycle_limit = 1000;   // Reworked from the line count

  sw_top dut_i (.*);

  initial
  begin
    ha_pclock = 1'b0;
    forever #20 ha_pclock = ~ha_pclock;   // 40 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  // One-cycle offer, returns at the falling edge of cycle 1
  task automatic strobe(input logic target, input logic le, input seq_word_t word);
    @(negedge ha_pclock);
    seq_valid = 1'b1;
    seq_target = target;
    little_endian = le;
    seq_word = word;
    @(negedge ha_pclock);
    seq_valid = 1'b0;
  endtask

  task automatic wait_quiet(input int n);
    repeat (n)
    begin
      @(negedge ha_pclock);
      check_flag("busy", busy, 1'b0);
      check_flag("result_valid", result_valid, 1'b0);
      check_flag("length_error", length_error, 1'b0);
    end
  endtask

  task automatic run_query(input logic le, input seq_word_t word, input logic err);
    strobe(1'b0, le, word);
    check_flag("length_error", length_error, err);
    check_flag("busy", busy, 1'b0);   // Query never starts a job
    wait_quiet(4);
  endtask

  task automatic run_target(input logic le, input seq_word_t word, input logic err,
                            input result_t exp, input logic bq, input seq_word_t bq_word);
    seq_len_t len;
    int       cycles;
    len = le ? {word.bytes[8], word.bytes[9]} : word.fields.length;   // Length as sent
    strobe(1'b1, le, word);
    cycles = 1;
    check_flag("length_error", length_error, err);
    check_flag("busy", busy, !err);
    if (err)
      wait_quiet(20);
    else
    begin
      if (bq)
      begin
        strobe(1'b0, le, bq_word);   // Offered while busy, must be dropped
        cycles = 3;
        check_flag("length_error", length_error, 1'b0);
      end
      while (result_valid !== 1'b1)
      begin
        check_flag("busy", busy, 1'b1);
        @(negedge ha_pclock);
        cycles++;
        if (cycles > max_bases + num_pe + 4)
          abort_run("No result_valid pulse after a valid target");
      end
      if (cycles != int'(len) + num_pe + 1)
        abort_run($sformatf("result_valid came %0d cycles after the strobe, expected %0d",
                            cycles, int'(len) + num_pe + 1));
      check_result("result", result, exp);
      check_flag("busy", busy, 1'b0);   // Falls with the pulse
      @(negedge ha_pclock);
      check_flag("result_valid", result_valid, 1'b0);
    end
  endtask

  always @(posedge ha_pclock)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
      abort_run("Timeout, the tests did not finish in time");
  end

  initial
  begin : main_flow
    int          fd;
    int          n;
    int          i;
    int          le_i;
    int          err_i;
    logic        bq;
    string       line;
    string       op;
    logic [79:0] word_raw;
    logic [15:0] res_raw;
    string       op_q[$];
    logic        le_q[$];
    seq_word_t   word_q[$];
    logic        err_q[$];
    result_t     res_q[$];
    reset = 1'b1;
    seq_valid = 1'b0;
    seq_target = 1'b0;
    little_endian = 1'b0;
    seq_word = '0;
    fd = $fopen("testbench/sw_tests.txt", "r");
    if (fd == 0)
      abort_run("Cannot open testbench/sw_tests.txt");
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n != 0 && $sscanf(line, "%s %d %h %d %h", op, le_i, word_raw, err_i, res_raw) == 5)
      begin
        op_q.push_back(op);   // Comment lines fail the scan
        le_q.push_back(le_i[0]);
        word_q.push_back(word_raw);
        err_q.push_back(err_i[0]);
        res_q.push_back(res_raw);
      end
    end
    $fclose(fd);
    cycle_limit = op_q.size() * (max_bases + num_pe + 10) + 16;
    repeat (16) @(posedge ha_pclock);
    @(negedge ha_pclock);
    reset = 1'b0;
    for (i = 0; i < op_q.size(); i++)
    begin
      if (op_q[i] == "idle")
        wait_quiet(8);
      else if (op_q[i] == "query")
        run_query(le_q[i], word_q[i], err_q[i]);
      else if (op_q[i] == "target")
      begin
        bq = (i + 1 < op_q.size()) && (op_q[i+1] == "busy-query");   // Rides on this job
        run_target(le_q[i], word_q[i], err_q[i], res_q[i], bq, bq ? word_q[i+1] : '0);
        if (bq)
          i++;
      end
      else
        abort_run({"Unknown operation in tests file: ", op_q[i]});
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- testbench/sw_assert.sv
// Concurrent checks on the scorer control outputs, bound into sw_top
`timescale 1ns/10ps

module sw_assert (
  input logic ha_pclock,
  input logic reset,
  input logic busy,
  input logic result_valid,
  input logic length_error
);

  assert property (@(posedge ha_pclock) disable iff (reset) result_valid |=> !result_valid)
    else $error("result_valid longer than one cycle");   // Single pulse per target

  assert property (@(posedge ha_pclock) disable iff (reset) length_error |=> !length_error)
    else $error("length_error longer than one cycle");

  // Busy drops together with the pulse, so look one cycle back
  assert property (@(posedge ha_pclock) disable iff (reset) result_valid |-> $past(busy))
    else $error("result_valid outside a busy job");

  assert property (@(posedge ha_pclock) $fell(reset) |-> !busy && !result_valid && !length_error)
    else $error("Control output high right after reset");

endmodule

bind sw_top sw_assert assert_i (.*);

//--- src/sw_top.sv
// Top level of the Smith-Waterman scorer; loader, systolic element chain and result collector
`timescale 1ns/10ps

module sw_top #(
  parameter int num_pe         = 8,     // Query length, one element per base
  parameter int match_score    = 5,
  parameter int mismatch_score = -4,
  parameter int gap_open       = -12,
  parameter int gap_extend     = -4
) (
  input  logic               ha_pclock,
  input  logic               reset,
  input  logic               seq_valid,
  input  logic               seq_target,
  input  logic               little_endian,
  input  sw_pkg::seq_word_t  seq_word,
  output logic               busy,
  output logic               length_error,
  output sw_pkg::result_t    result,
  output logic               result_valid
);
  import sw_pkg::*;

  base_t [num_pe-1:0]  query;   // Stored query, one base per element

  sw_link_if link [num_pe+1] ();   // Link 0 from loader, link num_pe to collector

  // Query must fit in one descriptor
  if (num_pe < 1 || num_pe > max_bases)
  begin : g_size_check
    $error("num_pe out of range");
  end

  seq_loader #(
    .num_pe(num_pe)
  ) loader_i (
    .ha_pclock     (ha_pclock),
    .reset         (reset),
    .seq_valid     (seq_valid),
    .seq_target    (seq_target),
    .little_endian (little_endian),
    .seq_word      (seq_word),
    .query         (query),
    .busy          (busy),
    .length_error  (length_error),
    .link          (link[0])
  );

  for (genvar i = 0; i < num_pe; i++)
  begin : g_pe
    sw_pe #(
      .match_score    (match_score),
      .mismatch_score (mismatch_score),
      .gap_open       (gap_open),
      .gap_extend     (gap_extend)
    ) pe_i (
      .ha_pclock  (ha_pclock),
      .reset      (reset),
      .query_base (query[i]),
      .up         (link[i]),
      .down       (link[i+1])
    );
  end

  score_collector collector_i (
    .ha_pclock     (ha_pclock),
    .reset         (reset),
    .little_endian (little_endian),
    .link          (link[num_pe]),
    .result        (result),
    .result_valid  (result_valid)
  );

endmodule

//--- src/score_collector.sv
// End of the scoring chain; captures the final best score and pulses it out
`timescale 1ns/10ps

module score_collector (
  input  logic             ha_pclock,
  input  logic             reset,
  input  logic             little_endian,   // Swap the two result bytes
  sw_link_if.down          link,            // Output of the last element
  output sw_pkg::result_t  result,
  output logic             result_valid
);
  import sw_pkg::*;

  result_t  best_word;   // Zero-extended chain maximum
  logic     capture;     // Last base of the target leaving the array

  assign capture   = link.valid && link.last;
  assign best_word = result_t'(link.best);

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
      result_valid <= 1'b0;
    else
      result_valid <= capture;   // One pulse per target
  end

  // Held until the next target finishes
  always_ff @(posedge ha_pclock)
  begin
    if (capture)
    begin
      if (little_endian)
        result <= {best_word[7:0], best_word[15:8]};
      else
        result <= best_word;
    end
  end

endmodule

//--- src/sw_pe.sv
// One systolic processing element; scores its query base against the passing target bases
`timescale 1ns/10ps

module sw_pe #(
  parameter int match_score    = 5,
  parameter int mismatch_score = -4,
  parameter int gap_open       = -12,   // Cost of the first gapped base
  parameter int gap_extend     = -4     // Cost of each further gapped base
) (
  input  logic           ha_pclock,
  input  logic           reset,
  input  sw_pkg::base_t  query_base,   // This element's row of the matrix
  sw_link_if.down        up,
  sw_link_if.up          down
);
  import sw_pkg::*;

  localparam int score_max = 2**$bits(score_t) - 1;

  score_t  prev_h;       // H of the previous column in this row
  score_t  diag_h;       // Previous incoming H, the diagonal
  score_t  e_reg;        // Horizontal gap state
  score_t  local_best;   // Best H seen in this row
  score_t  h_left;
  score_t  e_left;
  score_t  diag;
  score_t  row_best;
  score_t  e_new;
  score_t  f_new;
  score_t  h_new;
  score_t  best_now;
  int      pair_score;   // Match or mismatch

  // Saturate into 0..4095
  function automatic score_t clamp(input int v);
    if (v < 0)
      return '0;
    if (v > score_max)
      return score_t'(score_max);
    return score_t'(v);
  endfunction

  function automatic score_t max2(input score_t a, input score_t b);
    return (a > b) ? a : b;
  endfunction

  always_comb
  begin
    h_left     = up.first ? '0 : prev_h;   // New target restarts the row
    e_left     = up.first ? '0 : e_reg;
    diag       = up.first ? '0 : diag_h;
    row_best   = up.first ? '0 : local_best;
    pair_score = (up.base == query_base) ? match_score : mismatch_score;
    e_new      = max2(clamp(int'(h_left) + gap_open), clamp(int'(e_left) + gap_extend));
    f_new      = max2(clamp(int'(up.h) + gap_open), clamp(int'(up.f) + gap_extend));
    // Zero term covered by the clamp
    h_new      = max2(max2(clamp(int'(diag) + pair_score), e_new), f_new);
    best_now   = max2(row_best, h_new);
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
      down.valid <= 1'b0;
    else
      down.valid <= up.valid;
  end

  // Row state and forwarded payload, only on a valid base
  always_ff @(posedge ha_pclock)
  begin
    if (up.valid)
    begin
      down.base  <= up.base;
      down.first <= up.first;
      down.last  <= up.last;
      down.h     <= h_new;
      down.f     <= f_new;
      down.best  <= max2(up.best, best_now);   // Carries the chain maximum
      prev_h     <= h_new;
      diag_h     <= up.h;
      e_reg      <= e_new;
      local_best <= best_now;
    end
  end

endmodule

//--- src/seq_loader.sv
// Descriptor intake for the scorer; fixes byte order, checks lengths, holds the query, feeds the target
`timescale 1ns/10ps

module seq_loader #(
  parameter int num_pe = 8                       // Query length the array expects
) (
  input  logic                          ha_pclock,
  input  logic                          reset,
  input  logic                          seq_valid,      // One-cycle offer strobe
  input  logic                          seq_target,     // 1 target, 0 query
  input  logic                          little_endian,  // Word arrives byte-swapped
  input  sw_pkg::seq_word_t             seq_word,
  output sw_pkg::base_t [num_pe-1:0]    query,          // One base per element
  output logic                          busy,
  output logic                          length_error,
  sw_link_if.up                         link            // Head of the chain
);
  import sw_pkg::*;

  localparam seq_len_t pe_len = seq_len_t'(num_pe);

  seq_word_t               fixed_word;   // Word in native byte order
  seq_len_t                word_len;
  logic                    offer;        // Strobe seen while idle
  logic                    query_ok;
  logic                    target_ok;
  logic [2*max_bases-1:0]  tgt_bases;    // Target shift register
  seq_len_t                tgt_len;
  seq_len_t                cyc_cnt;      // Cycle within the current job, from 1

  // Byte-order fix through the byte view of the union
  always_comb
  begin
    fixed_word = seq_word;
    if (little_endian)
    begin
      fixed_word.bytes[9] = seq_word.bytes[8];   // Length bytes swap
      fixed_word.bytes[8] = seq_word.bytes[9];
      for (int i = 0; i < 8; i++)
      begin
        fixed_word.bytes[i] = seq_word.bytes[7-i];   // Bases field reversed
      end
    end
  end

  assign word_len  = fixed_word.fields.length;
  assign offer     = seq_valid && !busy;   // Busy strobes dropped silently
  assign query_ok  = !seq_target && (word_len == pe_len);
  assign target_ok = seq_target && (word_len != '0) && (word_len <= seq_len_t'(max_bases));

  // Query store, all A out of reset
  always_ff @(posedge ha_pclock)
  begin
    if (reset)
      query <= '0;
    else if (offer && query_ok)
    begin
      for (int i = 0; i < num_pe; i++)
      begin
        query[i] <= fixed_word.fields.bases[2*i +: 2];
      end
    end
  end

  // Job control
  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      busy         <= 1'b0;
      length_error <= 1'b0;
      cyc_cnt      <= '0;
    end
    else
    begin
      length_error <= offer && !query_ok && !target_ok;   // One-cycle pulse
      if (offer && target_ok)
      begin
        busy    <= 1'b1;
        cyc_cnt <= seq_len_t'(1);
      end
      else if (busy)
      begin
        if (cyc_cnt == tgt_len + pe_len)   // Drops as the result comes out
          busy <= 1'b0;
        cyc_cnt <= cyc_cnt + seq_len_t'(1);
      end
    end
  end

  // Target payload, shifted out two bits per cycle
  always_ff @(posedge ha_pclock)
  begin
    if (offer && target_ok)
    begin
      tgt_bases <= fixed_word.fields.bases;
      tgt_len   <= word_len;
    end
    else if (busy)
      tgt_bases <= tgt_bases >> 2;
  end

  // Bases on the link in cycles 1 to L
  assign link.valid = busy && (cyc_cnt <= tgt_len);
  assign link.base  = tgt_bases[1:0];
  assign link.first = (cyc_cnt == seq_len_t'(1));
  assign link.last  = (cyc_cnt == tgt_len);
  assign link.h     = '0;   // Row zero of the matrix
  assign link.f     = '0;
  assign link.best  = '0;

endmodule

//--- src/sw_link_if.sv
// Per-base link between neighbouring stages of the systolic scoring chain
`timescale 1ns/10ps

interface sw_link_if;
  import sw_pkg::*;

  logic    valid;   // Target base present
  base_t   base;    // Target base
  logic    first;   // First base of the target
  logic    last;    // Last base of the target
  score_t  h;       // Cell score from the stage above
  score_t  f;       // Open vertical gap score
  score_t  best;    // Running maximum so far

  // Driving side, loader or upstream element
  modport up
  (
    output valid, base, first, last, h, f, best
  );

  // Receiving side, downstream element or collector
  modport down
  (
    input valid, base, first, last, h, f, best
  );

endinterface

//--- src/sw_pkg.sv
// Shared types and sizes for the Smith-Waterman scorer, imported by the RTL and the testbench
package sw_pkg;

  // Largest sequence a descriptor can carry
  localparam int max_bases = 32;

  // Nucleotide code: A=0, C=1, G=2, T=3
  typedef logic [1:0] base_t;

  typedef logic [15:0] seq_len_t;   // Sequence length in bases

  // Unsigned, saturates at 4095
  typedef logic [11:0] score_t;

  typedef logic [15:0] result_t;    // Score as seen on the top-level port

  // Length on top, base 0 in the lowest two bits of bases
  typedef struct packed
  {
    seq_len_t                 length;   // Number of valid bases
    logic [2*max_bases-1:0]   bases;    // Packed 2-bit bases
  } seq_fields_t;

  // One descriptor word, 10 bytes
  // Field view for decoding, byte view for the endianness fix
  typedef union packed
  {
    seq_fields_t        fields;   // Length and bases
    logic [9:0][7:0]    bytes;    // Bytes 9..8 length, 7..0 bases
  } seq_word_t;

endpackage
